// ==== sim.f ====
+incdir+common
common/m_ext_pkg.sv
mul/mul_ex.sv
mul/mul_mem.sv
mul/mul_wb.sv
div/div_unit.sv
logic/m_ext_top.sv
testbench/tb_clk_gen.sv
testbench/m_ext_chk.sv
testbench/m_ext_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the M extension testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module m_ext_tb -f sim.f -o m_ext_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see $build_log"
  exit 1
fi

./obj_dir/m_ext_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "TB FAILED" "$sim_log"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ "$sim_status" -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi
echo "Simulation finished without failures"
exit 0

// ==== testbench/m_ext_tb.sv ====
`include "m_ext_cfg.svh"

module m_ext_tb;

  import m_ext_pkg::*;

  typedef struct packed {
    m_op_e              op;
    logic [`M_XLEN-1:0] rs1;
    logic [`M_XLEN-1:0] rs2;
    logic [`M_XLEN-1:0] exp;
    logic               drop;
  } test_case_t;

  logic               clk;
  logic               rst_n;
  logic               en;
  m_req_t             req;
  logic               busy;
  logic [`M_XLEN-1:0] result;

  test_case_t cases[$];
  string      names[$];
  int         cycle_limit;
  int         cycles;

  tb_clk_gen #(.PERIOD(8)) tb_clk_gen_inst (.clk(clk));

  m_ext_top m_ext_top_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .en     (en),
    .req    (req),
    .busy   (busy),
    .result (result)
  );

  task automatic add_case(input string name, input m_op_e op, input logic [31:0] rs1,
                          input logic [31:0] rs2, input logic [31:0] exp, input logic drop);
    cases.push_back(test_case_t'{op: op, rs1: rs1, rs2: rs2, exp: exp, drop: drop});
    names.push_back(name);
  endtask

  task automatic check_value(input string name, input logic [`M_XLEN-1:0] expected,
                             input logic [`M_XLEN-1:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Expected values worked out by hand from the RISC-V M rules
  task automatic build_table;
    add_case("mul_small",     OP_MUL,    32'd7,         32'd6,         32'h0000_002a, 1'b0);
    add_case("mul_neg",       OP_MUL,    32'hffff_fffd, 32'd5,         32'hffff_fff1, 1'b0);
    add_case("mul_ovf",       OP_MUL,    32'h8000_0000, 32'd2,         32'h0000_0000, 1'b0);
    add_case("mul_big",       OP_MUL,    32'h1234_5678, 32'h10,        32'h2345_6780, 1'b0);
    add_case("mulh_neg_pos",  OP_MULH,   32'hffff_ffff, 32'd1,         32'hffff_ffff, 1'b0);
    add_case("mulh_neg_neg",  OP_MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 1'b0);
    add_case("mulh_pos_pos",  OP_MULH,   32'h7fff_ffff, 32'h7fff_ffff, 32'h3fff_ffff, 1'b0);
    add_case("mulhsu_neg",    OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
    add_case("mulhsu_pos",    OP_MULHSU, 32'd2,         32'h8000_0000, 32'h0000_0001, 1'b0);
    add_case("mulhu_max",     OP_MULHU,  32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe, 1'b0);
    add_case("mulhu_mid",     OP_MULHU,  32'h8000_0000, 32'd4,         32'h0000_0002, 1'b0);
    add_case("div_pos_pos",   OP_DIV,    32'd20,        32'd3,         32'd6,         1'b0);
    add_case("div_neg_pos",   OP_DIV,    32'hffff_ffec, 32'd3,         32'hffff_fffa, 1'b0);
    add_case("div_pos_neg",   OP_DIV,    32'd20,        32'hffff_fffd, 32'hffff_fffa, 1'b0);
    add_case("div_neg_neg",   OP_DIV,    32'hffff_ffec, 32'hffff_fffd, 32'd6,         1'b0);
    add_case("div_by_zero",   OP_DIV,    32'd7,         32'd0,         32'hffff_ffff, 1'b0);
    add_case("div_ovf",       OP_DIV,    32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 1'b0);
    add_case("div_drop",      OP_DIV,    32'd100,       32'd7,         32'd14,        1'b1);
    add_case("divu_big",      OP_DIVU,   32'hffff_ffff, 32'd2,         32'h7fff_ffff, 1'b0);
    add_case("divu_zero",     OP_DIVU,   32'd5,         32'd0,         32'hffff_ffff, 1'b0);
    add_case("rem_pos_pos",   OP_REM,    32'd20,        32'd3,         32'd2,         1'b0);
    add_case("rem_neg_pos",   OP_REM,    32'hffff_ffec, 32'd3,         32'hffff_fffe, 1'b0);
    add_case("rem_pos_neg",   OP_REM,    32'd20,        32'hffff_fffd, 32'd2,         1'b0);
    add_case("rem_neg_neg",   OP_REM,    32'hffff_ffec, 32'hffff_fffd, 32'hffff_fffe, 1'b0);
    add_case("rem_by_zero",   OP_REM,    32'hffff_fff9, 32'd0,         32'hffff_fff9, 1'b0);
    add_case("rem_ovf",       OP_REM,    32'h8000_0000, 32'hffff_ffff, 32'd0,         1'b0);
    add_case("remu_big",      OP_REMU,   32'hffff_ffff, 32'd10,        32'd5,         1'b0);
    add_case("remu_zero",     OP_REMU,   32'h1234_5678, 32'd0,         32'h1234_5678, 1'b0);
  endtask

  // Hang guard
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst_n = 1'b0;
    en = 1'b0;
    req = '0;
    cycles = 0;
    cycle_limit = 0;
    build_table();
    cycle_limit = cases.size() * 40 + 50;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("reset_busy", '0, `M_XLEN'(busy));
    check_value("reset_result", '0, result);
    // Multiplies run back to back since en is raised again in the same time step
    foreach (cases[i]) begin
      req = m_req_t'{op: cases[i].op, rs1: cases[i].rs1, rs2: cases[i].rs2};
      en = 1'b1;
      @(negedge clk);
      en = 1'b0;
      if (cases[i].op[2]) begin
        check_value({names[i], "_busy"}, `M_XLEN'(1), `M_XLEN'(busy));
        if (cases[i].drop) begin
          // Offered during the division and must be ignored
          req = m_req_t'{op: OP_MUL, rs1: 32'd3, rs2: 32'd3};
          en = 1'b1;
          @(negedge clk);
          en = 1'b0;
        end
        while (busy) begin
          @(negedge clk);
        end
      end
      check_value(names[i], cases[i].exp, result);
    end
    en = 1'b0;
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== testbench/m_ext_chk.sv ====
`include "m_ext_cfg.svh"

module m_ext_chk (
  input logic               clk,
  input logic               rst_n,
  input logic               busy,
  input logic [`M_XLEN-1:0] result
);

  // Busy is clear once reset is released
  busy_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !busy)
    else $error("busy is high in the first cycle after reset");

  // A division holds busy for a fixed number of cycles
  busy_length: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(busy) |-> ##`M_DIV_CYCLES $fell(busy))
    else $error("busy did not fall after the expected division length");

  // Output holds its last value while the divider runs
  result_hold: assert property (@(posedge clk) disable iff (!rst_n)
    busy && $past(busy) |-> $stable(result))
    else $error("result changed while busy was high");

endmodule

bind m_ext_top m_ext_chk m_ext_chk_inst (
  .clk    (clk),
  .rst_n  (rst_n),
  .busy   (busy),
  .result (result)
);

// ==== testbench/tb_clk_gen.sv ====
module tb_clk_gen #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  // Free-running clock, low at time zero
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

// ==== logic/m_ext_top.sv ====
`include "m_ext_cfg.svh"

module m_ext_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               en,
  input  m_ext_pkg::m_req_t  req,
  output logic               busy,
  output logic [`M_XLEN-1:0] result
);

  import m_ext_pkg::*;

  logic                 issue;
  pp_t                  pp;
  logic [2*`M_XLEN-1:0] product;
  mul_stage_t           stage;
  logic [`M_XLEN-1:0]   div_result;

  // Requests offered while the divider runs are dropped
  assign issue = en && !busy;

  mul_ex mul_ex_inst (
    .req (req),
    .pp  (pp)
  );

  mul_mem mul_mem_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .issue   (issue),
    .req     (req),
    .pp      (pp),
    .product (product),
    .stage   (stage)
  );

  div_unit div_unit_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .issue  (issue),
    .req    (req),
    .busy   (busy),
    .result (div_result)
  );

  mul_wb mul_wb_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue      (issue),
    .req        (req),
    .product    (product),
    .stage      (stage),
    .div_result (div_result),
    .result     (result)
  );

endmodule

// ==== div/div_unit.sv ====
`include "m_ext_cfg.svh"

module div_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               issue,
  input  m_ext_pkg::m_req_t  req,
  output logic               busy,
  output logic [`M_XLEN-1:0] result
);

  import m_ext_pkg::*;

  localparam int CNT_W = $clog2(`M_DIV_CYCLES);

  logic               start;
  logic               op_signed;
  logic               neg_a;
  logic               neg_b;
  logic [`M_XLEN-1:0] mag_a;
  logic [`M_XLEN-1:0] mag_b;
  logic [CNT_W-1:0]   cnt;
  logic               last_step;
  logic [`M_XLEN-1:0] quo;
  logic [`M_XLEN-1:0] rem;
  logic [`M_XLEN-1:0] divisor;
  logic               want_rem;
  logic               quo_neg;
  logic               rem_neg;
  logic               div_zero;
  logic [`M_XLEN:0]   shifted;
  logic [`M_XLEN+1:0] trial;
  logic [`M_XLEN-1:0] quo_final;
  logic [`M_XLEN-1:0] rem_final;

  assign start     = issue && req.op[2];
  assign op_signed = (req.op == OP_DIV) || (req.op == OP_REM);
  assign neg_a     = op_signed && req.rs1[`M_XLEN-1];
  assign neg_b     = op_signed && req.rs2[`M_XLEN-1];

  // -2^31 maps to 0x80000000, which is still right as an unsigned magnitude
  assign mag_a = neg_a ? -req.rs1 : req.rs1;
  assign mag_b = neg_b ? -req.rs2 : req.rs2;

  // The last count value is the finish cycle
  assign last_step = (cnt == CNT_W'(`M_DIV_CYCLES - 1));

  // Bring in the next dividend bit and try the subtract
  assign shifted = {rem, quo[`M_XLEN-1]};
  assign trial   = {1'b0, shifted} - {2'b0, divisor};

  // Remainder takes the dividend sign, which also covers divide by zero
  always_comb begin
    quo_final = quo_neg ? -quo : quo;
    if (div_zero) begin
      quo_final = '1;
    end
    rem_final = rem_neg ? -rem : rem;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy   <= 1'b0;
      cnt    <= '0;
      result <= '0;
    end else if (start) begin
      busy <= 1'b1;
      cnt  <= '0;
    end else if (busy) begin
      if (last_step) begin
        busy   <= 1'b0;
        result <= want_rem ? rem_final : quo_final;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // Quotient bits shift in behind the dividend bits
  always_ff @(posedge clk) begin
    if (start) begin
      quo      <= mag_a;
      rem      <= '0;
      divisor  <= mag_b;
      want_rem <= req.op[1];
      quo_neg  <= neg_a ^ neg_b;
      rem_neg  <= neg_a;
      div_zero <= (req.rs2 == '0);
    end else if (busy && !last_step) begin
      if (!trial[`M_XLEN+1]) begin
        rem <= trial[`M_XLEN-1:0];
        quo <= {quo[`M_XLEN-2:0], 1'b1};
      end else begin
        rem <= shifted[`M_XLEN-1:0];
        quo <= {quo[`M_XLEN-2:0], 1'b0};
      end
    end
  end

endmodule

// ==== mul/mul_wb.sv ====
`include "m_ext_cfg.svh"

module mul_wb (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue,
  input  m_ext_pkg::m_req_t     req,
  input  logic [2*`M_XLEN-1:0]  product,
  input  m_ext_pkg::mul_stage_t stage,
  input  logic [`M_XLEN-1:0]    div_result,
  output logic [`M_XLEN-1:0]    result
);

  import m_ext_pkg::*;

  logic               div_sel;
  logic               a_signed;
  logic               b_signed;
  logic [`M_XLEN-1:0] hi_fix;
  logic [`M_XLEN-1:0] mul_result;

  assign a_signed = (stage.op == OP_MULH) || (stage.op == OP_MULHSU);
  assign b_signed = (stage.op == OP_MULH);

  // A negative signed operand adds -2^32 times the other operand,
  // which only touches the upper word
  always_comb begin
    hi_fix = product[2*`M_XLEN-1:`M_XLEN];
    if (a_signed && stage.rs1[`M_XLEN-1]) begin
      hi_fix = hi_fix - stage.rs2;
    end
    if (b_signed && stage.rs2[`M_XLEN-1]) begin
      hi_fix = hi_fix - stage.rs1;
    end
  end

  // Low word for MUL, upper word otherwise
  always_comb begin
    if (stage.op == OP_MUL) begin
      mul_result = product[`M_XLEN-1:0];
    end else begin
      mul_result = hi_fix;
    end
  end

  // Class of the last issued op
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_sel <= 1'b0;
    end else if (issue) begin
      div_sel <= req.op[2];
    end
  end

  assign result = div_sel ? div_result : mul_result;

endmodule

// ==== mul/mul_mem.sv ====
`include "m_ext_cfg.svh"

module mul_mem (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue,
  input  m_ext_pkg::m_req_t     req,
  input  m_ext_pkg::pp_t        pp,
  output logic [2*`M_XLEN-1:0]  product,
  output m_ext_pkg::mul_stage_t stage
);

  import m_ext_pkg::*;

  logic [2*`M_XLEN-1:0] lh_shifted;
  logic [2*`M_XLEN-1:0] hl_shifted;

  // Only multiply issues load the stage, so a divide leaves it untouched
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage <= '0;
    end else if (issue && !req.op[2]) begin
      stage <= mul_stage_t'{
        pp:  pp,
        op:  req.op,
        rs1: req.rs1,
        rs2: req.rs2
      };
    end
  end

  // Cross terms weigh 2^16
  assign lh_shifted = {16'b0, stage.pp.lh, 16'b0};
  assign hl_shifted = {16'b0, stage.pp.hl, 16'b0};

  // High term at bit 32 and low term at bit 0 concatenate without overlap
  assign product = {stage.pp.hh, stage.pp.ll} + lh_shifted + hl_shifted;

endmodule

// ==== mul/mul_ex.sv ====
module mul_ex (
  input  m_ext_pkg::m_req_t req,
  output m_ext_pkg::pp_t    pp
);

  import m_ext_pkg::*;

  logic [15:0] a_lo;
  logic [15:0] a_hi;
  logic [15:0] b_lo;
  logic [15:0] b_hi;

  // Operand halves, always treated as unsigned here
  assign a_lo = req.rs1[15:0];
  assign a_hi = req.rs1[31:16];
  assign b_lo = req.rs2[15:0];
  assign b_hi = req.rs2[31:16];

  // Sign handling is left to write-back
  assign pp = pp_t'{
    ll: 32'(a_lo) * 32'(b_lo),
    lh: 32'(a_lo) * 32'(b_hi),
    hl: 32'(a_hi) * 32'(b_lo),
    hh: 32'(a_hi) * 32'(b_hi)
  };

endmodule

// ==== common/m_ext_pkg.sv ====
`include "m_ext_cfg.svh"

package m_ext_pkg;

  // Operation codes follow RISC-V funct3 and bit 2 marks divide ops
  typedef enum logic [2:0] {
    OP_MUL    = 3'b000,
    OP_MULH   = 3'b001,
    OP_MULHSU = 3'b010,
    OP_MULHU  = 3'b011,
    OP_DIV    = 3'b100,
    OP_DIVU   = 3'b101,
    OP_REM    = 3'b110,
    OP_REMU   = 3'b111
  } m_op_e;

  typedef struct packed {
    m_op_e              op;
    logic [`M_XLEN-1:0] rs1;
    logic [`M_XLEN-1:0] rs2;
  } m_req_t;

  // Four unsigned 16x16 partial products
  typedef struct packed {
    logic [31:0] ll;
    logic [31:0] lh;
    logic [31:0] hl;
    logic [31:0] hh;
  } pp_t;

  // Registered multiply state
  typedef struct packed {
    pp_t                pp;
    m_op_e              op;
    logic [`M_XLEN-1:0] rs1;
    logic [`M_XLEN-1:0] rs2;
  } mul_stage_t;

endpackage

// ==== common/m_ext_cfg.svh ====
`ifndef M_EXT_CFG_SVH
`define M_EXT_CFG_SVH

// Operand and result width
`define M_XLEN 32

// Division stays busy for 32 bit steps plus a finish cycle
`define M_DIV_CYCLES 33

`endif
